//--- cortex_pkg.sv
// Shared constants for the audio analysis engine
// Referenced by scoped names from the RTL and the testbench
`default_nettype none

package cortex_pkg;

  // Local bus children, by block field of the address
  localparam int RST_BLK         = 0;
  localparam int CAPTURE_BLK     = 1;
  localparam int ENERGY_BLK      = 2;
  localparam int NUM_LB_CHILDREN = 3;

  // Bit 0 capture, bit 1 energy
  localparam int NUM_SOFT_RESETS = 2;

  // Register offsets inside each child
  localparam int REG_RST_VEC       = 0;
  localparam int REG_CAP_CTRL      = 0;
  localparam int REG_CAP_COUNT     = 1;
  localparam int REG_CAP_DROPS     = 2;
  localparam int REG_ENERGY_SUM    = 0;
  localparam int REG_ENERGY_FRAMES = 1;

  // Signed PCM sample
  localparam int PCM_SAMPLE_W = 16;

  // Read value for holes in the map
  localparam logic [31:0] DEFAULT_DATA_VAL = 32'hdeadbabe;

endpackage

`default_nettype wire

//--- lb_splitter.sv
// Local bus decoder for the cortex children
// Block field picks the child, responses are merged back combinationally
`timescale 1ns/1ps
`default_nettype none

module lb_splitter #(
  parameter int LB_DATA_W     = 32,
  parameter int LB_ADDR_W     = 16,
  parameter int LB_ADDR_BLK_W = 4
) (
  input  wire                                                  clk,
  input  wire                                                  rst_n,
  input  wire                                                  lb_wr_en,
  input  wire                                                  lb_rd_en,
  input  wire  [LB_ADDR_W-1:0]                                 lb_addr,
  input  wire  [LB_DATA_W-1:0]                                 lb_wr_data,
  output logic                                                 lb_wr_valid,
  output logic                                                 lb_rd_valid,
  output logic [LB_DATA_W-1:0]                                 lb_rd_data,
  output logic [cortex_pkg::NUM_LB_CHILDREN-1:0]               chld_lb_wr_en,
  output logic [cortex_pkg::NUM_LB_CHILDREN-1:0]               chld_lb_rd_en,
  output logic [LB_ADDR_W-LB_ADDR_BLK_W-1:0]                   chld_lb_addr,
  output logic [LB_DATA_W-1:0]                                 chld_lb_wr_data,
  input  wire  [cortex_pkg::NUM_LB_CHILDREN-1:0]               chld_lb_wr_valid,
  input  wire  [cortex_pkg::NUM_LB_CHILDREN-1:0]               chld_lb_rd_valid,
  input  wire  [cortex_pkg::NUM_LB_CHILDREN-1:0][LB_DATA_W-1:0] chld_lb_rd_data
);

  localparam int CHLD_ADDR_W = LB_ADDR_W - LB_ADDR_BLK_W;
  localparam int NUM_CHLD    = cortex_pkg::NUM_LB_CHILDREN;

  logic [LB_ADDR_BLK_W-1:0] blk_sel;
  logic                     blk_unmapped;
  logic                     miss_wr_valid;
  logic                     miss_rd_valid;

  // Top bits select the child
  assign blk_sel      = lb_addr[LB_ADDR_W-1 -: LB_ADDR_BLK_W];
  assign blk_unmapped = (blk_sel >= NUM_CHLD);

  // Offset and data go to every child
  assign chld_lb_addr    = lb_addr[CHLD_ADDR_W-1:0];
  assign chld_lb_wr_data = lb_wr_data;

  always_comb begin
    for (int i = 0; i < NUM_CHLD; i++) begin
      chld_lb_wr_en[i] = lb_wr_en && (blk_sel == i);
      chld_lb_rd_en[i] = lb_rd_en && (blk_sel == i);
    end
  end

  // Nobody home at this block, answer one cycle later ourselves
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      miss_wr_valid <= 1'b0;
      miss_rd_valid <= 1'b0;
    end else begin
      miss_wr_valid <= lb_wr_en && blk_unmapped;
      miss_rd_valid <= lb_rd_en && blk_unmapped;
    end
  end

  assign lb_wr_valid = (|chld_lb_wr_valid) || miss_wr_valid;
  assign lb_rd_valid = (|chld_lb_rd_valid) || miss_rd_valid;

  // Single outstanding access, so at most one child responds
  always_comb begin
    lb_rd_data = LB_DATA_W'(cortex_pkg::DEFAULT_DATA_VAL);
    for (int i = 0; i < NUM_CHLD; i++) begin
      if (chld_lb_rd_valid[i]) begin
        lb_rd_data = chld_lb_rd_data[i];
      end
    end
  end

endmodule

`default_nettype wire

//--- rst_cntrl.sv
// Software soft reset register for the audio blocks
// Each output is rst_n gated by its register bit, one flop deep
`timescale 1ns/1ps
`default_nettype none

module rst_cntrl #(
  parameter int LB_DATA_W     = 32,
  parameter int LB_ADDR_W     = 16,
  parameter int LB_ADDR_BLK_W = 4
) (
  input  wire                                       clk,
  input  wire                                       rst_n,
  input  wire                                       lb_wr_en,
  input  wire                                       lb_rd_en,
  input  wire  [LB_ADDR_W-LB_ADDR_BLK_W-1:0]        lb_addr,
  input  wire  [LB_DATA_W-1:0]                      lb_wr_data,
  output logic                                      lb_wr_valid,
  output logic                                      lb_rd_valid,
  output logic [LB_DATA_W-1:0]                      lb_rd_data,
  output logic [cortex_pkg::NUM_SOFT_RESETS-1:0]    cntrl_rst_n
);

  localparam int NUM_RST = cortex_pkg::NUM_SOFT_RESETS;

  logic [NUM_RST-1:0] rst_vec;

  // Bus side, answer every access next cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rst_vec     <= '1;
      lb_wr_valid <= 1'b0;
      lb_rd_valid <= 1'b0;
      lb_rd_data  <= '0;
    end else begin
      lb_wr_valid <= lb_wr_en;
      lb_rd_valid <= lb_rd_en;
      if (lb_wr_en && (lb_addr == cortex_pkg::REG_RST_VEC)) begin
        rst_vec <= lb_wr_data[NUM_RST-1:0];
      end
      if (lb_addr == cortex_pkg::REG_RST_VEC) begin
        lb_rd_data <= LB_DATA_W'(rst_vec);
      end else begin
        lb_rd_data <= LB_DATA_W'(cortex_pkg::DEFAULT_DATA_VAL);
      end
    end
  end

  // Low while rst_n is low or bit is cleared
  always_ff @(posedge clk) begin
    cntrl_rst_n <= rst_vec & {NUM_RST{rst_n}};
  end

endmodule

`default_nettype wire

//--- pcm_capture.sv
// PCM sample producer
// Accepts strobed samples while enabled, writes them to the frame buffer
// and counts accepted and dropped samples for software
`timescale 1ns/1ps
`default_nettype none

module pcm_capture #(
  parameter int LB_DATA_W     = 32,
  parameter int LB_ADDR_W     = 16,
  parameter int LB_ADDR_BLK_W = 4
) (
  input  wire                                        clk,
  input  wire                                        rst_n,
  input  wire                                        lb_wr_en,
  input  wire                                        lb_rd_en,
  input  wire  [LB_ADDR_W-LB_ADDR_BLK_W-1:0]         lb_addr,
  input  wire  [LB_DATA_W-1:0]                       lb_wr_data,
  output logic                                       lb_wr_valid,
  output logic                                       lb_rd_valid,
  output logic [LB_DATA_W-1:0]                       lb_rd_data,
  input  wire                                        aud_sample_valid,
  input  wire  signed [cortex_pkg::PCM_SAMPLE_W-1:0] aud_sample,
  input  wire                                        pcm_space,
  output logic                                       pcm_wr_en,
  output logic signed [cortex_pkg::PCM_SAMPLE_W-1:0] pcm_wr_data
);

  logic                 cap_en;
  logic [LB_DATA_W-1:0] sample_count;
  logic [LB_DATA_W-1:0] drop_count;
  logic                 take_sample;
  logic                 drop_sample;

  // Space is sampled with the strobe
  assign take_sample = aud_sample_valid && cap_en && pcm_space;
  assign drop_sample = aud_sample_valid && cap_en && !pcm_space;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cap_en       <= 1'b0;
      sample_count <= '0;
      drop_count   <= '0;
      pcm_wr_en    <= 1'b0;
      lb_wr_valid  <= 1'b0;
      lb_rd_valid  <= 1'b0;
      lb_rd_data   <= '0;
    end else begin
      // Buffer write and counters on one edge
      pcm_wr_en <= take_sample;
      if (take_sample) begin
        sample_count <= sample_count + 1'b1;
      end
      if (drop_sample) begin
        drop_count <= drop_count + 1'b1;
      end

      // Only CTRL is writable, counters ack and ignore
      lb_wr_valid <= lb_wr_en;
      lb_rd_valid <= lb_rd_en;
      if (lb_wr_en && (lb_addr == cortex_pkg::REG_CAP_CTRL)) begin
        cap_en <= lb_wr_data[0];
      end
      case (lb_addr)
        cortex_pkg::REG_CAP_CTRL:  lb_rd_data <= LB_DATA_W'(cap_en);
        cortex_pkg::REG_CAP_COUNT: lb_rd_data <= sample_count;
        cortex_pkg::REG_CAP_DROPS: lb_rd_data <= drop_count;
        default:                   lb_rd_data <= LB_DATA_W'(cortex_pkg::DEFAULT_DATA_VAL);
      endcase
    end
  end

  // Sample payload
  always_ff @(posedge clk) begin
    if (take_sample) begin
      pcm_wr_data <= aud_sample;
    end
  end

endmodule

`default_nettype wire

//--- pcm_buffer.sv
// Ping-pong PCM frame memory between capture and energy
// Banks fill in turn and are handed out oldest first
`timescale 1ns/1ps
`default_nettype none

module pcm_buffer #(
  parameter int NUM_AUD_SAMPLES = 128
) (
  input  wire                                        clk,
  input  wire                                        rst_n,
  input  wire                                        pcm_wr_en,
  input  wire  signed [cortex_pkg::PCM_SAMPLE_W-1:0] pcm_wr_data,
  output logic                                       pcm_space,
  output logic                                       pcm_rdy,
  input  wire                                        pcm_rden,
  input  wire  [$clog2(NUM_AUD_SAMPLES)-1:0]         pcm_addr,
  output logic                                       pcm_rd_valid,
  output logic signed [cortex_pkg::PCM_SAMPLE_W-1:0] pcm_rdata,
  input  wire                                        pcm_done
);

  localparam int                IDX_W    = $clog2(NUM_AUD_SAMPLES);
  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(NUM_AUD_SAMPLES - 1);

  logic signed [cortex_pkg::PCM_SAMPLE_W-1:0] mem [2*NUM_AUD_SAMPLES];

  logic             wr_bank;
  logic [IDX_W-1:0] wr_idx;
  logic             rd_bank;
  logic [1:0]       bank_full;
  logic             wr_accept;

  assign wr_accept = pcm_wr_en && !bank_full[wr_bank];

  // Look past a write that closes the current bank
  // so a back-to-back strobe sees the next bank's state
  assign pcm_space = (pcm_wr_en && (wr_idx == LAST_IDX)) ? !bank_full[!wr_bank]
                                                         : !bank_full[wr_bank];

  // Read pointer always sits on the oldest bank
  assign pcm_rdy = bank_full[rd_bank];

  // Bank select is the top address bit
  always_ff @(posedge clk) begin
    if (wr_accept) begin
      mem[{wr_bank, wr_idx}] <= pcm_wr_data;
    end
    pcm_rdata <= mem[{rd_bank, pcm_addr}];
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_bank      <= 1'b0;
      wr_idx       <= '0;
      rd_bank      <= 1'b0;
      bank_full    <= '0;
      pcm_rd_valid <= 1'b0;
    end else begin
      pcm_rd_valid <= pcm_rden;
      if (wr_accept) begin
        // Index wraps on its own, frame is a power of two
        wr_idx <= wr_idx + 1'b1;
        if (wr_idx == LAST_IDX) begin
          bank_full[wr_bank] <= 1'b1;
          wr_bank            <= !wr_bank;
        end
      end
      // Consumer finished, free oldest bank
      if (pcm_done) begin
        bank_full[rd_bank] <= 1'b0;
        rd_bank            <= !rd_bank;
      end
    end
  end

endmodule

`default_nettype wire

//--- pcm_energy.sv
// PCM frame energy consumer
// Streams each full frame out of the buffer and sums sample magnitudes
// Result and frame count are readable over the local bus
`timescale 1ns/1ps
`default_nettype none

module pcm_energy #(
  parameter int LB_DATA_W       = 32,
  parameter int LB_ADDR_W       = 16,
  parameter int LB_ADDR_BLK_W   = 4,
  parameter int NUM_AUD_SAMPLES = 128
) (
  input  wire                                        clk,
  input  wire                                        rst_n,
  input  wire                                        lb_wr_en,
  input  wire                                        lb_rd_en,
  input  wire  [LB_ADDR_W-LB_ADDR_BLK_W-1:0]         lb_addr,
  input  wire  [LB_DATA_W-1:0]                       lb_wr_data,
  output logic                                       lb_wr_valid,
  output logic                                       lb_rd_valid,
  output logic [LB_DATA_W-1:0]                       lb_rd_data,
  input  wire                                        pcm_rdy,
  output logic                                       pcm_rden,
  output logic [$clog2(NUM_AUD_SAMPLES)-1:0]         pcm_addr,
  input  wire                                        pcm_rd_valid,
  input  wire  signed [cortex_pkg::PCM_SAMPLE_W-1:0] pcm_rdata,
  output logic                                       pcm_done
);

  localparam int                SMP_W    = cortex_pkg::PCM_SAMPLE_W;
  localparam int                IDX_W    = $clog2(NUM_AUD_SAMPLES);
  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(NUM_AUD_SAMPLES - 1);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ISSUE,
    ST_DRAIN,
    ST_DONE
  } state_t;

  state_t               state;
  logic [IDX_W-1:0]     rx_cnt;
  logic [LB_DATA_W-1:0] acc;
  logic [LB_DATA_W-1:0] energy_sum;
  logic [LB_DATA_W-1:0] frame_count;
  logic signed [SMP_W:0] smp_ext;
  logic [SMP_W:0]       smp_mag;

  // One extra bit holds the magnitude of the most negative sample
  assign smp_ext = pcm_rdata;
  assign smp_mag = smp_ext[SMP_W] ? (SMP_W+1)'(-smp_ext) : (SMP_W+1)'(smp_ext);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state       <= ST_IDLE;
      pcm_rden    <= 1'b0;
      pcm_addr    <= '0;
      pcm_done    <= 1'b0;
      rx_cnt      <= '0;
      acc         <= '0;
      energy_sum  <= '0;
      frame_count <= '0;
    end else begin
      pcm_done <= 1'b0;

      // Returns overlap the issue phase
      if (pcm_rd_valid) begin
        acc    <= acc + LB_DATA_W'(smp_mag);
        rx_cnt <= rx_cnt + 1'b1;
      end

      case (state)
        ST_IDLE: begin
          // Wait out the done pulse since the bank is freed a cycle later
          if (pcm_rdy && !pcm_done) begin
            state    <= ST_ISSUE;
            pcm_rden <= 1'b1;
            pcm_addr <= '0;
            rx_cnt   <= '0;
            acc      <= '0;
          end
        end
        ST_ISSUE: begin
          // One read per cycle
          pcm_addr <= pcm_addr + 1'b1;
          if (pcm_addr == LAST_IDX) begin
            pcm_rden <= 1'b0;
            state    <= ST_DRAIN;
          end
        end
        ST_DRAIN: begin
          if (pcm_rd_valid && (rx_cnt == LAST_IDX)) begin
            state <= ST_DONE;
          end
        end
        default: begin
          // Publish and hand the bank back
          energy_sum  <= acc;
          frame_count <= frame_count + 1'b1;
          pcm_done    <= 1'b1;
          state       <= ST_IDLE;
        end
      endcase
    end
  end

  // Bus side with both registers read only
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      lb_wr_valid <= 1'b0;
      lb_rd_valid <= 1'b0;
      lb_rd_data  <= '0;
    end else begin
      // Write data has nowhere to go
      lb_wr_valid <= lb_wr_en;
      lb_rd_valid <= lb_rd_en;
      case (lb_addr)
        cortex_pkg::REG_ENERGY_SUM:    lb_rd_data <= energy_sum;
        cortex_pkg::REG_ENERGY_FRAMES: lb_rd_data <= frame_count;
        default: lb_rd_data <= LB_DATA_W'(cortex_pkg::DEFAULT_DATA_VAL);
      endcase
    end
  end

endmodule

`default_nettype wire

//--- cortex.sv
// Top level of the audio analysis engine
// Local bus is split to the reset controller, capture and energy blocks,
// samples flow capture -> ping-pong buffer -> energy
`timescale 1ns/1ps
`default_nettype none

module cortex #(
  parameter int LB_DATA_W       = 32,
  parameter int LB_ADDR_W       = 16,
  parameter int LB_ADDR_BLK_W   = 4,
  parameter int NUM_AUD_SAMPLES = 128
) (
  input  wire                                        clk,
  input  wire                                        rst_n,
  input  wire                                        lb_wr_en,
  input  wire                                        lb_rd_en,
  input  wire  [LB_ADDR_W-1:0]                       lb_addr,
  input  wire  [LB_DATA_W-1:0]                       lb_wr_data,
  output logic                                       lb_wr_valid,
  output logic                                       lb_rd_valid,
  output logic [LB_DATA_W-1:0]                       lb_rd_data,
  input  wire                                        aud_sample_valid,
  input  wire  signed [cortex_pkg::PCM_SAMPLE_W-1:0] aud_sample
);

  localparam int CHLD_ADDR_W = LB_ADDR_W - LB_ADDR_BLK_W;
  localparam int NUM_CHLD    = cortex_pkg::NUM_LB_CHILDREN;
  localparam int IDX_W       = $clog2(NUM_AUD_SAMPLES);

  // Child bus
  logic [NUM_CHLD-1:0]                chld_wr_en;
  logic [NUM_CHLD-1:0]                chld_rd_en;
  logic [CHLD_ADDR_W-1:0]             chld_addr;
  logic [LB_DATA_W-1:0]               chld_wr_data;
  logic [NUM_CHLD-1:0]                chld_wr_valid;
  logic [NUM_CHLD-1:0]                chld_rd_valid;
  logic [NUM_CHLD-1:0][LB_DATA_W-1:0] chld_rd_data;

  logic [cortex_pkg::NUM_SOFT_RESETS-1:0] soft_rst_n;

  // PCM path
  logic                                       pcm_wr_en;
  logic signed [cortex_pkg::PCM_SAMPLE_W-1:0] pcm_wr_data;
  logic                                       pcm_space;
  logic                                       pcm_rdy;
  logic                                       pcm_rden;
  logic [IDX_W-1:0]                           pcm_addr;
  logic                                       pcm_rd_valid;
  logic signed [cortex_pkg::PCM_SAMPLE_W-1:0] pcm_rdata;
  logic                                       pcm_done;

  lb_splitter #(
    .LB_DATA_W     (LB_DATA_W),
    .LB_ADDR_W     (LB_ADDR_W),
    .LB_ADDR_BLK_W (LB_ADDR_BLK_W)
  ) lb_splitter_inst (
    .clk              (clk),
    .rst_n            (rst_n),
    .lb_wr_en         (lb_wr_en),
    .lb_rd_en         (lb_rd_en),
    .lb_addr          (lb_addr),
    .lb_wr_data       (lb_wr_data),
    .lb_wr_valid      (lb_wr_valid),
    .lb_rd_valid      (lb_rd_valid),
    .lb_rd_data       (lb_rd_data),
    .chld_lb_wr_en    (chld_wr_en),
    .chld_lb_rd_en    (chld_rd_en),
    .chld_lb_addr     (chld_addr),
    .chld_lb_wr_data  (chld_wr_data),
    .chld_lb_wr_valid (chld_wr_valid),
    .chld_lb_rd_valid (chld_rd_valid),
    .chld_lb_rd_data  (chld_rd_data)
  );

  // Runs on the global reset only
  rst_cntrl #(
    .LB_DATA_W     (LB_DATA_W),
    .LB_ADDR_W     (LB_ADDR_W),
    .LB_ADDR_BLK_W (LB_ADDR_BLK_W)
  ) rst_cntrl_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .lb_wr_en    (chld_wr_en[cortex_pkg::RST_BLK]),
    .lb_rd_en    (chld_rd_en[cortex_pkg::RST_BLK]),
    .lb_addr     (chld_addr),
    .lb_wr_data  (chld_wr_data),
    .lb_wr_valid (chld_wr_valid[cortex_pkg::RST_BLK]),
    .lb_rd_valid (chld_rd_valid[cortex_pkg::RST_BLK]),
    .lb_rd_data  (chld_rd_data[cortex_pkg::RST_BLK]),
    .cntrl_rst_n (soft_rst_n)
  );

  // Soft reset bit 0
  pcm_capture #(
    .LB_DATA_W     (LB_DATA_W),
    .LB_ADDR_W     (LB_ADDR_W),
    .LB_ADDR_BLK_W (LB_ADDR_BLK_W)
  ) pcm_capture_inst (
    .clk              (clk),
    .rst_n            (soft_rst_n[0]),
    .lb_wr_en         (chld_wr_en[cortex_pkg::CAPTURE_BLK]),
    .lb_rd_en         (chld_rd_en[cortex_pkg::CAPTURE_BLK]),
    .lb_addr          (chld_addr),
    .lb_wr_data       (chld_wr_data),
    .lb_wr_valid      (chld_wr_valid[cortex_pkg::CAPTURE_BLK]),
    .lb_rd_valid      (chld_rd_valid[cortex_pkg::CAPTURE_BLK]),
    .lb_rd_data       (chld_rd_data[cortex_pkg::CAPTURE_BLK]),
    .aud_sample_valid (aud_sample_valid),
    .aud_sample       (aud_sample),
    .pcm_space        (pcm_space),
    .pcm_wr_en        (pcm_wr_en),
    .pcm_wr_data      (pcm_wr_data)
  );

  // Keeps full banks across soft resets of either side
  pcm_buffer #(
    .NUM_AUD_SAMPLES (NUM_AUD_SAMPLES)
  ) pcm_buffer_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .pcm_wr_en    (pcm_wr_en),
    .pcm_wr_data  (pcm_wr_data),
    .pcm_space    (pcm_space),
    .pcm_rdy      (pcm_rdy),
    .pcm_rden     (pcm_rden),
    .pcm_addr     (pcm_addr),
    .pcm_rd_valid (pcm_rd_valid),
    .pcm_rdata    (pcm_rdata),
    .pcm_done     (pcm_done)
  );

  // Soft reset bit 1
  pcm_energy #(
    .LB_DATA_W       (LB_DATA_W),
    .LB_ADDR_W       (LB_ADDR_W),
    .LB_ADDR_BLK_W   (LB_ADDR_BLK_W),
    .NUM_AUD_SAMPLES (NUM_AUD_SAMPLES)
  ) pcm_energy_inst (
    .clk          (clk),
    .rst_n        (soft_rst_n[1]),
    .lb_wr_en     (chld_wr_en[cortex_pkg::ENERGY_BLK]),
    .lb_rd_en     (chld_rd_en[cortex_pkg::ENERGY_BLK]),
    .lb_addr      (chld_addr),
    .lb_wr_data   (chld_wr_data),
    .lb_wr_valid  (chld_wr_valid[cortex_pkg::ENERGY_BLK]),
    .lb_rd_valid  (chld_rd_valid[cortex_pkg::ENERGY_BLK]),
    .lb_rd_data   (chld_rd_data[cortex_pkg::ENERGY_BLK]),
    .pcm_rdy      (pcm_rdy),
    .pcm_rden     (pcm_rden),
    .pcm_addr     (pcm_addr),
    .pcm_rd_valid (pcm_rd_valid),
    .pcm_rdata    (pcm_rdata),
    .pcm_done     (pcm_done)
  );

endmodule

`default_nettype wire

//--- cortex_tb.sv
// Self-checking testbench for the cortex audio analysis engine
// Drives random PCM samples and local bus accesses and checks energy against a model
`timescale 1ns/1ps
`default_nettype none

module cortex_tb;

  localparam int LB_DATA_W       = 32;
  localparam int LB_ADDR_W       = 16;
  localparam int LB_ADDR_BLK_W   = 4;
  localparam int NUM_AUD_SAMPLES = 16;
  localparam int CHLD_ADDR_W     = LB_ADDR_W - LB_ADDR_BLK_W;
  localparam int SMP_W           = cortex_pkg::PCM_SAMPLE_W;
  localparam int BUS_TIMEOUT     = 20;
  localparam int POLL_TIMEOUT    = 200;
  localparam logic [31:0] DEF_VAL  = cortex_pkg::DEFAULT_DATA_VAL;
  localparam logic [31:0] ALL_RUN  = 32'((1 << cortex_pkg::NUM_SOFT_RESETS) - 1);

  logic                    clk = 1'b0;
  logic                    rst_n;
  logic                    lb_wr_en;
  logic                    lb_rd_en;
  logic [LB_ADDR_W-1:0]    lb_addr;
  logic [LB_DATA_W-1:0]    lb_wr_data;
  logic                    lb_wr_valid;
  logic                    lb_rd_valid;
  logic [LB_DATA_W-1:0]    lb_rd_data;
  logic                    aud_sample_valid;
  logic signed [SMP_W-1:0] aud_sample;

  integer      seed = 32'hd8d1eda0;
  // Model state
  int          model_q[$];
  int unsigned exp_count;
  int unsigned exp_drops;
  int unsigned exp_frames;

  cortex #(
    .LB_DATA_W       (LB_DATA_W),
    .LB_ADDR_W       (LB_ADDR_W),
    .LB_ADDR_BLK_W   (LB_ADDR_BLK_W),
    .NUM_AUD_SAMPLES (NUM_AUD_SAMPLES)
  ) uut (
    .clk              (clk),
    .rst_n            (rst_n),
    .lb_wr_en         (lb_wr_en),
    .lb_rd_en         (lb_rd_en),
    .lb_addr          (lb_addr),
    .lb_wr_data       (lb_wr_data),
    .lb_wr_valid      (lb_wr_valid),
    .lb_rd_valid      (lb_rd_valid),
    .lb_rd_data       (lb_rd_data),
    .aud_sample_valid (aud_sample_valid),
    .aud_sample       (aud_sample)
  );

  // 8 ns clock
  always #4 clk = ~clk;

  function automatic logic [LB_ADDR_W-1:0] lb_address(input int blk, input int off);
    return {LB_ADDR_BLK_W'(blk), CHLD_ADDR_W'(off)};
  endfunction

  task automatic stop_with_error(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    $display("TB FAILED");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                             input string msg);
    assert (actual == expected) else begin
      $display("[FAIL] %0t ns: %s, got %h, expected %h", $time, msg, actual, expected);
      $display("TB FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // Strobe for one cycle and expect the ack on the next edge
  task automatic bus_write(input int blk, input int off, input logic [31:0] data);
    int cycles;
    lb_addr    = lb_address(blk, off);
    lb_wr_data = data;
    lb_wr_en   = 1'b1;
    @(posedge clk);
    #1;
    lb_wr_en = 1'b0;
    cycles   = 1;
    while (!lb_wr_valid && cycles < BUS_TIMEOUT) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (!lb_wr_valid) stop_with_error("no write acknowledge came back on the local bus");
    assert (cycles == 1) else
      stop_with_error("write acknowledge did not arrive one cycle after the strobe");
  endtask

  task automatic bus_read(input int blk, input int off, output logic [31:0] data);
    int cycles;
    lb_addr  = lb_address(blk, off);
    lb_rd_en = 1'b1;
    @(posedge clk);
    #1;
    lb_rd_en = 1'b0;
    cycles   = 1;
    while (!lb_rd_valid && cycles < BUS_TIMEOUT) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (!lb_rd_valid) stop_with_error("no read response came back on the local bus");
    assert (cycles == 1) else
      stop_with_error("read response did not arrive one cycle after the strobe");
    data = lb_rd_data;
  endtask

  task automatic read_expect(input int blk, input int off, input logic [31:0] expected,
                             input string msg);
    logic [31:0] got;
    bus_read(blk, off, got);
    check_equal(got, expected, msg);
  endtask

  // Random samples with random idle gaps
  // First accept_count go to the model and the rest count as drops
  task automatic send_samples(input int count, input int accept_count, input bit enabled);
    logic signed [SMP_W-1:0] s;
    int                      gap;
    for (int i = 0; i < count; i++) begin
      s   = SMP_W'($random(seed));
      gap = 1 + int'($unsigned($random(seed)) % 4);
      aud_sample       = s;
      aud_sample_valid = 1'b1;
      @(posedge clk);
      #1;
      aud_sample_valid = 1'b0;
      if (enabled && i < accept_count) begin
        model_q.push_back(int'(s));
        exp_count++;
      end else if (enabled) begin
        exp_drops++;
      end
      repeat (gap) begin
        @(posedge clk);
        #1;
      end
    end
  endtask

  task automatic wait_frames(input int unsigned target);
    logic [31:0] frames;
    int          polls;
    polls = 0;
    bus_read(cortex_pkg::ENERGY_BLK, cortex_pkg::REG_ENERGY_FRAMES, frames);
    while (frames < target && polls < POLL_TIMEOUT) begin
      bus_read(cortex_pkg::ENERGY_BLK, cortex_pkg::REG_ENERGY_FRAMES, frames);
      polls++;
    end
    if (frames < target) stop_with_error("timed out waiting for the energy frame count");
    check_equal(frames, target, "energy frame count");
  endtask

  // Oldest model frame against the published sum
  task automatic check_next_frame();
    int unsigned expected_sum;
    int          s;
    logic [31:0] got;
    if (model_q.size() < NUM_AUD_SAMPLES) begin
      stop_with_error("model holds no complete frame to compare");
    end
    expected_sum = 0;
    for (int i = 0; i < NUM_AUD_SAMPLES; i++) begin
      s = model_q.pop_front();
      expected_sum += (s < 0) ? int'(-s) : s;
    end
    exp_frames++;
    wait_frames(exp_frames);
    bus_read(cortex_pkg::ENERGY_BLK, cortex_pkg::REG_ENERGY_SUM, got);
    check_equal(got, expected_sum, "frame energy sum");
  endtask

  task automatic check_counters();
    read_expect(cortex_pkg::CAPTURE_BLK, cortex_pkg::REG_CAP_COUNT, exp_count,
                "accepted sample count");
    read_expect(cortex_pkg::CAPTURE_BLK, cortex_pkg::REG_CAP_DROPS, exp_drops,
                "dropped sample count");
  endtask

  initial begin
    rst_n            = 1'b0;
    lb_wr_en         = 1'b0;
    lb_rd_en         = 1'b0;
    lb_addr          = '0;
    lb_wr_data       = '0;
    aud_sample_valid = 1'b0;
    aud_sample       = '0;
    exp_count        = 0;
    exp_drops        = 0;
    exp_frames       = 0;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // Soft resets trail rst_n by a flop
    repeat (2) begin
      @(posedge clk);
      #1;
    end

    // Reset values
    read_expect(cortex_pkg::RST_BLK, cortex_pkg::REG_RST_VEC, ALL_RUN, "soft reset vector");
    read_expect(cortex_pkg::CAPTURE_BLK, cortex_pkg::REG_CAP_CTRL, 32'h0, "capture enable");
    check_counters();
    read_expect(cortex_pkg::ENERGY_BLK, cortex_pkg::REG_ENERGY_SUM, 32'h0, "energy sum");
    read_expect(cortex_pkg::ENERGY_BLK, cortex_pkg::REG_ENERGY_FRAMES, 32'h0, "frame count");

    // Bus decode
    bus_write(cortex_pkg::CAPTURE_BLK, cortex_pkg::REG_CAP_CTRL, 32'h1);
    read_expect(cortex_pkg::CAPTURE_BLK, cortex_pkg::REG_CAP_CTRL, 32'h1, "enable set");
    bus_write(cortex_pkg::CAPTURE_BLK, cortex_pkg::REG_CAP_CTRL, 32'h0);
    read_expect(cortex_pkg::CAPTURE_BLK, cortex_pkg::REG_CAP_CTRL, 32'h0, "enable clear");
    bus_write(cortex_pkg::CAPTURE_BLK, cortex_pkg::REG_CAP_COUNT, 32'h1234_5678);
    read_expect(cortex_pkg::CAPTURE_BLK, cortex_pkg::REG_CAP_COUNT, 32'h0, "read-only count");
    bus_write(5, 0, 32'hffff_ffff);
    read_expect(5, 0, DEF_VAL, "unmapped block");
    read_expect(15, 7, DEF_VAL, "unmapped top block");
    read_expect(cortex_pkg::RST_BLK, 1, DEF_VAL, "unused reset offset");
    read_expect(cortex_pkg::CAPTURE_BLK, 3, DEF_VAL, "unused capture offset");
    read_expect(cortex_pkg::ENERGY_BLK, 2, DEF_VAL, "unused energy offset");

    // Disabled capture ignores samples
    send_samples(NUM_AUD_SAMPLES + 3, 0, 1'b0);
    // Long enough for a wrongly captured frame to reach the frame count
    repeat (2 * NUM_AUD_SAMPLES) begin
      @(posedge clk);
      #1;
    end
    check_counters();
    read_expect(cortex_pkg::ENERGY_BLK, cortex_pkg::REG_ENERGY_FRAMES, 32'h0,
                "frame count while disabled");

    // Frame energy one frame at a time
    bus_write(cortex_pkg::CAPTURE_BLK, cortex_pkg::REG_CAP_CTRL, 32'h1);
    for (int f = 0; f < 4; f++) begin
      send_samples(NUM_AUD_SAMPLES, NUM_AUD_SAMPLES, 1'b1);
      check_next_frame();
    end
    check_counters();

    // Back-pressure with energy held in soft reset
    bus_write(cortex_pkg::RST_BLK, cortex_pkg::REG_RST_VEC, 32'h1);
    read_expect(cortex_pkg::RST_BLK, cortex_pkg::REG_RST_VEC, 32'h1, "energy held");
    send_samples(3 * NUM_AUD_SAMPLES, 2 * NUM_AUD_SAMPLES, 1'b1);
    check_counters();
    // Frame count restarts from zero in soft reset
    exp_frames = 0;
    bus_write(cortex_pkg::RST_BLK, cortex_pkg::REG_RST_VEC, ALL_RUN);
    read_expect(cortex_pkg::RST_BLK, cortex_pkg::REG_RST_VEC, ALL_RUN, "energy released");
    check_next_frame();
    check_next_frame();

    // Buffer accepts again
    send_samples(NUM_AUD_SAMPLES, NUM_AUD_SAMPLES, 1'b1);
    check_next_frame();
    check_counters();

    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
cortex_pkg.sv
lb_splitter.sv
rst_cntrl.sv
pcm_capture.sv
pcm_buffer.sv
pcm_energy.sv
cortex.sv
cortex_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build cortex_tb with Verilator and run it; exit status is the simulation result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module cortex_tb \
  -f verilog.f -o cortex_tb_sim \
  && ./obj_dir/cortex_tb_sim \
  || exit 1
